/* common/core_types_pkg.sv */
// Sizes shared by the core's rename, register file and ROB logic
// The register file has two read ports per bank, selected by a one-bit port number
package core_types_pkg;

  // Physical register file
  localparam int PR_COUNT = 64;
  localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

  // Register file banks, indexed by the low bits of the physical register
  localparam int PRF_BANK_COUNT = 4;
  localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

  // Reorder buffer
  localparam int ROB_ENTRIES = 64;
  localparam int LOG_ROB_ENTRIES = $clog2(ROB_ENTRIES);

endpackage

/* common/alu_ops_pkg.sv */
// ALU op encodings for the immediate-operand path
// The low three bits follow funct3, the top bit selects arithmetic right shift
package alu_ops_pkg;

  localparam int XLEN = 32;
  localparam int IMM_WIDTH = 12;

  // Only the low bits of B are used as a shift amount
  localparam int SHAMT_WIDTH = $clog2(XLEN);

  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;
  localparam alu_op_t ALU_SRA  = 4'b1101;

endpackage

/* design/alu.sv */
// Combinational integer ALU, no subtract since only immediate ops reach it
// Unknown op codes give zero
`timescale 1ns/1ps

module alu (
  input  alu_ops_pkg::alu_op_t          op,
  input  logic [alu_ops_pkg::XLEN-1:0]  A,
  input  logic [alu_ops_pkg::XLEN-1:0]  B,
  output logic [alu_ops_pkg::XLEN-1:0]  out
);
  import alu_ops_pkg::*;

  logic [SHAMT_WIDTH-1:0] shamt;
  logic                   lt_signed;
  logic                   lt_unsigned;

  assign shamt = B[SHAMT_WIDTH-1:0];
  assign lt_signed = $signed(A) < $signed(B);
  assign lt_unsigned = A < B;

  always_comb begin
    case (op)
      ALU_ADD: begin
        out = A + B;
      end
      ALU_SLL: begin
        out = A << shamt;
      end
      ALU_SLT: begin
        out = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        out = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        out = A ^ B;
      end
      ALU_SRL: begin
        out = A >> shamt;
      end
      ALU_OR: begin
        out = A | B;
      end
      ALU_AND: begin
        out = A & B;
      end
      // Sign bit of A fills from the left
      ALU_SRA: begin
        out = $signed(A) >>> shamt;
      end
      default: begin
        out = '0;
      end
    endcase
  end

endmodule

/* alu_imm_pipeline/alu_imm_issue_stage.sv */
// First pipeline register, one instruction deep
// Accepts a new instruction when empty or when its item moves on in the same cycle
`timescale 1ns/1ps

module alu_imm_issue_stage (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        issue_valid,
  output logic                                        issue_ready,
  input  alu_ops_pkg::alu_op_t                        issue_op,
  input  logic [alu_ops_pkg::IMM_WIDTH-1:0]           issue_imm12,
  input  logic                                        issue_A_forward,
  input  logic                                        issue_A_is_zero,
  input  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank,
  input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     issue_dest_PR,
  input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  issue_ROB_index,
  output logic                                        op_valid,
  input  logic                                        op_ready,
  output alu_ops_pkg::alu_op_t                        op_op,
  output logic [alu_ops_pkg::IMM_WIDTH-1:0]           op_imm12,
  output logic                                        op_A_forward,
  output logic                                        op_A_is_zero,
  output logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] op_A_bank,
  output logic [core_types_pkg::LOG_PR_COUNT-1:0]     op_dest_PR,
  output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  op_ROB_index
);
  import alu_ops_pkg::*;
  import core_types_pkg::*;

  alu_op_t                     op_q;
  logic [IMM_WIDTH-1:0]        imm_q;
  logic                        fwd_q;
  logic                        zero_q;
  logic [LOG_PRF_BANK_COUNT-1:0] bank_q;
  logic [LOG_PR_COUNT-1:0]     pr_q;
  logic [LOG_ROB_ENTRIES-1:0]  rob_q;
  logic                        accept;

  assign issue_ready = ~op_valid | op_ready;
  assign accept = issue_valid & issue_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (~nRST) begin
      op_valid <= 1'b0;
    end else if (issue_ready) begin
      op_valid <= issue_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      op_q   <= issue_op;
      imm_q  <= issue_imm12;
      fwd_q  <= issue_A_forward;
      zero_q <= issue_A_is_zero;
      bank_q <= issue_A_bank;
      pr_q   <= issue_dest_PR;
      rob_q  <= issue_ROB_index;
    end
  end

  assign op_op        = op_q;
  assign op_imm12     = imm_q;
  assign op_A_forward = fwd_q;
  assign op_A_is_zero = zero_q;
  assign op_A_bank    = bank_q;
  assign op_dest_PR   = pr_q;
  assign op_ROB_index = rob_q;

endmodule

/* alu_imm_pipeline/alu_imm_operand_stage.sv */
// Holds one instruction until its A operand is present on the forward or read buses
// The bus data is only sampled in the cycle the item leaves, nothing is buffered
`timescale 1ns/1ps

module alu_imm_operand_stage (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        op_valid,
  output logic                                        op_ready,
  input  alu_ops_pkg::alu_op_t                        op_op,
  input  logic [alu_ops_pkg::IMM_WIDTH-1:0]           op_imm12,
  input  logic                                        op_A_forward,
  input  logic                                        op_A_is_zero,
  input  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] op_A_bank,
  input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     op_dest_PR,
  input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  op_ROB_index,
  input  logic                                        A_reg_read_ack,
  input  logic                                        A_reg_read_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][alu_ops_pkg::XLEN-1:0]
                                                      reg_read_data_by_bank_by_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][alu_ops_pkg::XLEN-1:0]
                                                      forward_data_by_bank,
  output logic                                        ex_valid,
  input  logic                                        ex_ready,
  output alu_ops_pkg::alu_op_t                        ex_op,
  output logic [alu_ops_pkg::XLEN-1:0]                ex_A,
  output logic [alu_ops_pkg::XLEN-1:0]                ex_B,
  output logic [core_types_pkg::LOG_PR_COUNT-1:0]     ex_dest_PR,
  output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  ex_ROB_index
);
  import alu_ops_pkg::*;
  import core_types_pkg::*;

  logic                          valid_q;
  alu_op_t                       op_q;
  logic [IMM_WIDTH-1:0]          imm_q;
  logic                          fwd_q;
  logic                          zero_q;
  logic [LOG_PRF_BANK_COUNT-1:0] bank_q;
  logic [LOG_PR_COUNT-1:0]       pr_q;
  logic [LOG_ROB_ENTRIES-1:0]    rob_q;
  logic                          a_avail;

  // Forwarded and zero operands need no register file read
  assign a_avail = fwd_q | zero_q | A_reg_read_ack;

  assign ex_valid = valid_q & a_avail;
  assign op_ready = ~valid_q | (a_avail & ex_ready);

  always_ff @(posedge CLK or negedge nRST) begin
    if (~nRST) begin
      valid_q <= 1'b0;
    end else if (op_ready) begin
      valid_q <= op_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (op_valid & op_ready) begin
      op_q   <= op_op;
      imm_q  <= op_imm12;
      fwd_q  <= op_A_forward;
      zero_q <= op_A_is_zero;
      bank_q <= op_A_bank;
      pr_q   <= op_dest_PR;
      rob_q  <= op_ROB_index;
    end
  end

  // Forward wins over zero, the acked read port is the fallback
  always_comb begin
    if (fwd_q) begin
      ex_A = forward_data_by_bank[bank_q];
    end else if (zero_q) begin
      ex_A = '0;
    end else begin
      ex_A = reg_read_data_by_bank_by_port[bank_q][A_reg_read_port];
    end
  end

  assign ex_B = {{(XLEN-IMM_WIDTH){imm_q[IMM_WIDTH-1]}}, imm_q};

  assign ex_op        = op_q;
  assign ex_dest_PR   = pr_q;
  assign ex_ROB_index = rob_q;

endmodule

/* alu_imm_pipeline/alu_imm_exec_stage.sv */
// ALU followed by the writeback register
// Writeback outputs only change when the register is empty or WB_ready is high
`timescale 1ns/1ps

module alu_imm_exec_stage (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        ex_valid,
  output logic                                        ex_ready,
  input  alu_ops_pkg::alu_op_t                        ex_op,
  input  logic [alu_ops_pkg::XLEN-1:0]                ex_A,
  input  logic [alu_ops_pkg::XLEN-1:0]                ex_B,
  input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     ex_dest_PR,
  input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  ex_ROB_index,
  output logic                                        WB_valid,
  input  logic                                        WB_ready,
  output logic [alu_ops_pkg::XLEN-1:0]                WB_data,
  output logic [core_types_pkg::LOG_PR_COUNT-1:0]     WB_PR,
  output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  WB_ROB_index
);
  import alu_ops_pkg::*;

  logic [XLEN-1:0] alu_out;

  alu u_alu (
    .op  (ex_op),
    .A   (ex_A),
    .B   (ex_B),
    .out (alu_out)
  );

  assign ex_ready = ~WB_valid | WB_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (~nRST) begin
      WB_valid <= 1'b0;
    end else if (ex_ready) begin
      WB_valid <= ex_valid;
    end
  end

  // Result and tags load together, so a stalled writeback stays consistent
  always_ff @(posedge CLK) begin
    if (ex_valid & ex_ready) begin
      WB_data      <= alu_out;
      WB_PR        <= ex_dest_PR;
      WB_ROB_index <= ex_ROB_index;
    end
  end

endmodule

/* alu_imm_pipeline/alu_imm_pipeline.sv */
// Three-stage immediate ALU pipeline: issue, operand collect, execute and writeback
// Up to three instructions in flight, results leave in issue order
`timescale 1ns/1ps

module alu_imm_pipeline (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        issue_valid,
  output logic                                        issue_ready,
  input  alu_ops_pkg::alu_op_t                        issue_op,
  input  logic [alu_ops_pkg::IMM_WIDTH-1:0]           issue_imm12,
  input  logic                                        issue_A_forward,
  input  logic                                        issue_A_is_zero,
  input  logic [core_types_pkg::LOG_PRF_BANK_COUNT-1:0] issue_A_bank,
  input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     issue_dest_PR,
  input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  issue_ROB_index,
  input  logic                                        A_reg_read_ack,
  input  logic                                        A_reg_read_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][1:0][alu_ops_pkg::XLEN-1:0]
                                                      reg_read_data_by_bank_by_port,
  input  logic [core_types_pkg::PRF_BANK_COUNT-1:0][alu_ops_pkg::XLEN-1:0]
                                                      forward_data_by_bank,
  output logic                                        WB_valid,
  input  logic                                        WB_ready,
  output logic [alu_ops_pkg::XLEN-1:0]                WB_data,
  output logic [core_types_pkg::LOG_PR_COUNT-1:0]     WB_PR,
  output logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  WB_ROB_index
);
  import alu_ops_pkg::*;
  import core_types_pkg::*;

  // Issue to operand stage
  logic                          op_valid;
  logic                          op_ready;
  alu_op_t                       op_op;
  logic [IMM_WIDTH-1:0]          op_imm12;
  logic                          op_A_forward;
  logic                          op_A_is_zero;
  logic [LOG_PRF_BANK_COUNT-1:0] op_A_bank;
  logic [LOG_PR_COUNT-1:0]       op_dest_PR;
  logic [LOG_ROB_ENTRIES-1:0]    op_ROB_index;

  // Operand to exec stage
  logic                          ex_valid;
  logic                          ex_ready;
  alu_op_t                       ex_op;
  logic [XLEN-1:0]               ex_A;
  logic [XLEN-1:0]               ex_B;
  logic [LOG_PR_COUNT-1:0]       ex_dest_PR;
  logic [LOG_ROB_ENTRIES-1:0]    ex_ROB_index;

  alu_imm_issue_stage u_issue (
    .CLK             (CLK),
    .nRST            (nRST),
    .issue_valid     (issue_valid),
    .issue_ready     (issue_ready),
    .issue_op        (issue_op),
    .issue_imm12     (issue_imm12),
    .issue_A_forward (issue_A_forward),
    .issue_A_is_zero (issue_A_is_zero),
    .issue_A_bank    (issue_A_bank),
    .issue_dest_PR   (issue_dest_PR),
    .issue_ROB_index (issue_ROB_index),
    .op_valid        (op_valid),
    .op_ready        (op_ready),
    .op_op           (op_op),
    .op_imm12        (op_imm12),
    .op_A_forward    (op_A_forward),
    .op_A_is_zero    (op_A_is_zero),
    .op_A_bank       (op_A_bank),
    .op_dest_PR      (op_dest_PR),
    .op_ROB_index    (op_ROB_index)
  );

  alu_imm_operand_stage u_operand (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .op_valid                      (op_valid),
    .op_ready                      (op_ready),
    .op_op                         (op_op),
    .op_imm12                      (op_imm12),
    .op_A_forward                  (op_A_forward),
    .op_A_is_zero                  (op_A_is_zero),
    .op_A_bank                     (op_A_bank),
    .op_dest_PR                    (op_dest_PR),
    .op_ROB_index                  (op_ROB_index),
    .A_reg_read_ack                (A_reg_read_ack),
    .A_reg_read_port               (A_reg_read_port),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
    .forward_data_by_bank          (forward_data_by_bank),
    .ex_valid                      (ex_valid),
    .ex_ready                      (ex_ready),
    .ex_op                         (ex_op),
    .ex_A                          (ex_A),
    .ex_B                          (ex_B),
    .ex_dest_PR                    (ex_dest_PR),
    .ex_ROB_index                  (ex_ROB_index)
  );

  alu_imm_exec_stage u_exec (
    .CLK          (CLK),
    .nRST         (nRST),
    .ex_valid     (ex_valid),
    .ex_ready     (ex_ready),
    .ex_op        (ex_op),
    .ex_A         (ex_A),
    .ex_B         (ex_B),
    .ex_dest_PR   (ex_dest_PR),
    .ex_ROB_index (ex_ROB_index),
    .WB_valid     (WB_valid),
    .WB_ready     (WB_ready),
    .WB_data      (WB_data),
    .WB_PR        (WB_PR),
    .WB_ROB_index (WB_ROB_index)
  );

endmodule

/* tests/tb_clock_gen.sv */
// Free-running 8 ns clock, reset held low for the first 10 rising edges
// Reset is released 1 ns after an edge, like the rest of the stimulus
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic nRST
);
  localparam int RESET_CYCLES = 10;

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    nRST = 1'b1;
  end

endmodule

/* tests/alu_imm_pipeline_properties.sv */
// Writeback handshake and reset checks, bound into the pipeline top level
`timescale 1ns/1ps

module alu_imm_pipeline_properties (
  input  logic                                        CLK,
  input  logic                                        nRST,
  input  logic                                        issue_ready,
  input  logic                                        WB_valid,
  input  logic                                        WB_ready,
  input  logic [alu_ops_pkg::XLEN-1:0]                WB_data,
  input  logic [core_types_pkg::LOG_PR_COUNT-1:0]     WB_PR,
  input  logic [core_types_pkg::LOG_ROB_ENTRIES-1:0]  WB_ROB_index
);

  // A stalled writeback keeps its valid and all of its payload
  wb_hold_on_stall: assert property (
    @(posedge CLK) disable iff (!nRST)
    (WB_valid && !WB_ready) |=>
      (WB_valid && $stable(WB_data) && $stable(WB_PR) && $stable(WB_ROB_index))
  ) else $error("writeback outputs changed while WB_ready was low");

  wb_idle_in_reset: assert property (
    @(posedge CLK) !nRST |-> !WB_valid
  ) else $error("WB_valid high during reset");

  // First edge after release
  ready_after_reset: assert property (
    @(posedge CLK) $rose(nRST) |-> issue_ready
  ) else $error("issue_ready low in the first cycle after reset");

endmodule

/* tests/alu_imm_pipeline_tb.sv */
// Testbench for the immediate ALU pipeline with register file, forwarding and ROB models
// ROB indices count up mod 64 and identify in-flight instructions uniquely
`timescale 1ns/1ps

module alu_imm_pipeline_tb;
  import alu_ops_pkg::*;
  import core_types_pkg::*;

  localparam logic [31:0] LFSR_SEED = 32'h0cf0_3676;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int ISSUE_TO_WB_CYCLES = 3;
  localparam int CYCLES_PER_ISSUE = 20;
  localparam int DRAIN_CYCLES = 50;
  localparam int TOTAL_ISSUES = 9 + 40 + 8 + 60 + 3 + 8;

  typedef struct packed {
    logic [XLEN-1:0]            data;
    logic [LOG_PR_COUNT-1:0]    pr;
    logic [LOG_ROB_ENTRIES-1:0] rob;
    logic [31:0]                issue_cyc;
    logic                       chk_lat;
  } exp_t;

  typedef struct packed {
    logic [LOG_ROB_ENTRIES-1:0] rob;
    logic                       port;
    logic [1:0]                 delay;
  } read_req_t;

  logic                                        CLK;
  logic                                        nRST;
  logic                                        issue_valid;
  logic                                        issue_ready;
  alu_op_t                                     issue_op;
  logic [IMM_WIDTH-1:0]                        issue_imm12;
  logic                                        issue_A_forward;
  logic                                        issue_A_is_zero;
  logic [LOG_PRF_BANK_COUNT-1:0]               issue_A_bank;
  logic [LOG_PR_COUNT-1:0]                     issue_dest_PR;
  logic [LOG_ROB_ENTRIES-1:0]                  issue_ROB_index;
  logic                                        A_reg_read_ack;
  logic                                        A_reg_read_port;
  logic [PRF_BANK_COUNT-1:0][1:0][XLEN-1:0]    reg_read_data_by_bank_by_port;
  logic [PRF_BANK_COUNT-1:0][XLEN-1:0]         forward_data_by_bank;
  logic                                        WB_valid;
  logic                                        WB_ready;
  logic [XLEN-1:0]                             WB_data;
  logic [LOG_PR_COUNT-1:0]                     WB_PR;
  logic [LOG_ROB_ENTRIES-1:0]                  WB_ROB_index;

  exp_t                       exp_q[$];
  read_req_t                  need_q[$];
  exp_t                       wb_exp;
  read_req_t                  cur_req;
  logic                       req_busy;
  int                         req_wait;
  logic [31:0]                lfsr_state;
  logic [31:0]                cyc;
  logic [LOG_ROB_ENTRIES-1:0] rob_ctr;
  logic                       toggle_wb;
  int                         errors;
  int                         checks;
  int                         tests_run;
  int                         tests_failed;
  int                         test_err_start;
  int                         issued;
  int                         retired;
  string                      test_name;

  tb_clock_gen u_clk (
    .CLK  (CLK),
    .nRST (nRST)
  );

  alu_imm_pipeline dut0 (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .issue_valid                   (issue_valid),
    .issue_ready                   (issue_ready),
    .issue_op                      (issue_op),
    .issue_imm12                   (issue_imm12),
    .issue_A_forward               (issue_A_forward),
    .issue_A_is_zero               (issue_A_is_zero),
    .issue_A_bank                  (issue_A_bank),
    .issue_dest_PR                 (issue_dest_PR),
    .issue_ROB_index               (issue_ROB_index),
    .A_reg_read_ack                (A_reg_read_ack),
    .A_reg_read_port               (A_reg_read_port),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
    .forward_data_by_bank          (forward_data_by_bank),
    .WB_valid                      (WB_valid),
    .WB_ready                      (WB_ready),
    .WB_data                       (WB_data),
    .WB_PR                         (WB_PR),
    .WB_ROB_index                  (WB_ROB_index)
  );

  bind alu_imm_pipeline alu_imm_pipeline_properties props0 (
    .CLK          (CLK),
    .nRST         (nRST),
    .issue_ready  (issue_ready),
    .WB_valid     (WB_valid),
    .WB_ready     (WB_ready),
    .WB_data      (WB_data),
    .WB_PR        (WB_PR),
    .WB_ROB_index (WB_ROB_index)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic alu_op_t op_by_index(input int i);
    case (i)
      0: return ALU_ADD;
      1: return ALU_SLL;
      2: return ALU_SLT;
      3: return ALU_SLTU;
      4: return ALU_XOR;
      5: return ALU_SRL;
      6: return ALU_OR;
      7: return ALU_AND;
      default: return ALU_SRA;
    endcase
  endfunction

  // RV32I immediate semantics, written out bit by bit
  function automatic logic [31:0] ref_result(input alu_op_t op, input logic [31:0] a,
                                             input logic [11:0] imm);
    logic [31:0] b;
    logic [4:0]  sh;
    logic [31:0] fill;
    b = {{20{imm[11]}}, imm};
    sh = b[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SLL:  return a << sh;
      ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      ALU_SLTU: return {31'b0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SRA:  return (a >> sh) | fill;
      default:  return 32'h0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("MISMATCH t=%0t %s got=%h expected=%h", $time, name, got, expected);
    end
  endtask

  task automatic load_regfile;
    for (int b = 0; b < PRF_BANK_COUNT; b++) begin
      forward_data_by_bank[LOG_PRF_BANK_COUNT'(b)] = rand_bits(32);
      for (int p = 0; p < 2; p++) begin
        reg_read_data_by_bank_by_port[LOG_PRF_BANK_COUNT'(b)][1'(p)] = rand_bits(32);
      end
    end
  endtask

  // Called 1 ns after an edge, returns 1 ns after the accepting edge
  task automatic send(input alu_op_t op, input logic [11:0] imm, input logic fwd,
                      input logic zero, input logic [1:0] bank, input logic chk_lat);
    logic        port;
    logic [1:0]  delay;
    logic [31:0] a;
    logic        done;
    exp_t        e;
    read_req_t   r;
    port = 1'(rand_bits(1));
    delay = 2'(rand_bits(2));
    issue_valid = 1'b1;
    issue_op = op;
    issue_imm12 = imm;
    issue_A_forward = fwd;
    issue_A_is_zero = zero;
    issue_A_bank = bank;
    issue_dest_PR = LOG_PR_COUNT'(rand_bits(LOG_PR_COUNT));
    issue_ROB_index = rob_ctr;
    done = 1'b0;
    while (!done) begin
      if (toggle_wb) begin
        WB_ready = 1'(rand_bits(1));
      end
      @(negedge CLK);
      if (issue_ready) begin
        if (fwd) begin
          a = forward_data_by_bank[bank];
        end else if (zero) begin
          a = 32'h0;
        end else begin
          a = reg_read_data_by_bank_by_port[bank][port];
        end
        e.data = ref_result(op, a, imm);
        e.pr = issue_dest_PR;
        e.rob = rob_ctr;
        e.issue_cyc = cyc;
        e.chk_lat = chk_lat;
        exp_q.push_back(e);
        if (!fwd && !zero) begin
          r.rob = rob_ctr;
          r.port = port;
          r.delay = delay;
          need_q.push_back(r);
        end
        rob_ctr = rob_ctr + 6'd1;
        issued++;
        done = 1'b1;
      end
      @(posedge CLK);
      #1;
    end
  endtask

  // Waits for all outstanding results, but gives up after DRAIN_CYCLES
  task automatic drain;
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge CLK);
      waited++;
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_start = errors;
    toggle_wb = 1'b0;
    WB_ready = 1'b1;
    load_regfile();
  endtask

  task automatic end_test;
    issue_valid = 1'b0;
    drain();
    check_value("scoreboard depth", 32'(exp_q.size()), 32'd0);
    tests_run++;
    if (errors != test_err_start) begin
      tests_failed++;
      $display("test %0d %s: FAIL, %0d errors", tests_run, test_name, errors - test_err_start);
    end else begin
      $display("test %0d %s: ok", tests_run, test_name);
    end
  endtask

  initial begin
    cyc = '0;
    forever begin
      @(posedge CLK);
      cyc <= cyc + 32'd1;
    end
  end

  // Register file read port: acks the oldest instruction that needs a read,
  // and drops the ack once that instruction shows up in the writeback register
  initial begin
    A_reg_read_ack = 1'b0;
    A_reg_read_port = 1'b0;
    req_busy = 1'b0;
    req_wait = 0;
    forever begin
      @(posedge CLK);
      #1;
      if (req_busy && A_reg_read_ack && WB_valid && WB_ROB_index == cur_req.rob) begin
        A_reg_read_ack = 1'b0;
        req_busy = 1'b0;
        void'(need_q.pop_front());
      end
      if (!req_busy && need_q.size() != 0) begin
        cur_req = need_q[0];
        req_busy = 1'b1;
        req_wait = int'(cur_req.delay);
      end
      if (req_busy && !A_reg_read_ack) begin
        if (req_wait == 0) begin
          A_reg_read_ack = 1'b1;
          A_reg_read_port = cur_req.port;
        end else begin
          req_wait--;
        end
      end
    end
  end

  // Scoreboard, sampled mid-cycle ahead of the transfer edge
  initial begin
    forever begin
      @(negedge CLK);
      if (nRST && WB_valid && WB_ready) begin
        retired++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR t=%0t: writeback of ROB index %0d with no instruction outstanding",
                   $time, WB_ROB_index);
        end else begin
          wb_exp = exp_q.pop_front();
          check_value("WB_data", WB_data, wb_exp.data);
          check_value("WB_PR", 32'(WB_PR), 32'(wb_exp.pr));
          check_value("WB_ROB_index", 32'(WB_ROB_index), 32'(wb_exp.rob));
          if (wb_exp.chk_lat) begin
            check_value("WB latency", cyc - wb_exp.issue_cyc, ISSUE_TO_WB_CYCLES);
          end
        end
      end
    end
  end

  initial begin
    repeat (TOTAL_ISSUES * CYCLES_PER_ISSUE) @(posedge CLK);
    $display("ERROR: run did not finish in time, %0d results still outstanding",
             exp_q.size());
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    lfsr_state = LFSR_SEED;
    rob_ctr = '0;
    toggle_wb = 1'b0;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    issued = 0;
    retired = 0;
    issue_valid = 1'b0;
    issue_op = ALU_ADD;
    issue_imm12 = '0;
    issue_A_forward = 1'b0;
    issue_A_is_zero = 1'b0;
    issue_A_bank = '0;
    issue_dest_PR = '0;
    issue_ROB_index = '0;
    reg_read_data_by_bank_by_port = '0;
    forward_data_by_bank = '0;
    WB_ready = 1'b0;
    wait (nRST === 1'b1);
    @(posedge CLK);
    #1;

    begin_test("every op, forwarded A");
    for (int i = 0; i < 9; i++) begin
      send(op_by_index(i), 12'(rand_bits(12)), 1'b1, 1'b0, 2'(rand_bits(2)), 1'b1);
    end
    end_test();

    begin_test("register file A, random ack");
    for (int i = 0; i < 40; i++) begin
      send(op_by_index(int'(rand_bits(4)) % 9), 12'(rand_bits(12)), 1'b0, 1'b0,
           2'(rand_bits(2)), 1'b0);
    end
    end_test();

    begin_test("zero A");
    for (int i = 0; i < 8; i++) begin
      send(op_by_index(int'(rand_bits(4)) % 9), 12'(rand_bits(12)), 1'b0, 1'b1,
           2'(rand_bits(2)), 1'b0);
    end
    end_test();

    begin_test("random WB_ready, mixed sources");
    toggle_wb = 1'b1;
    for (int i = 0; i < 60; i++) begin
      case (rand_bits(2))
        0: send(op_by_index(int'(rand_bits(4)) % 9), 12'(rand_bits(12)), 1'b1, 1'b0,
                2'(rand_bits(2)), 1'b0);
        1: send(op_by_index(int'(rand_bits(4)) % 9), 12'(rand_bits(12)), 1'b0, 1'b1,
                2'(rand_bits(2)), 1'b0);
        default: send(op_by_index(int'(rand_bits(4)) % 9), 12'(rand_bits(12)), 1'b0, 1'b0,
                      2'(rand_bits(2)), 1'b0);
      endcase
    end
    toggle_wb = 1'b0;
    WB_ready = 1'b1;
    issue_valid = 1'b0;
    drain();
    check_value("pending reads", 32'(need_q.size()), 32'd0);
    check_value("retired count", 32'(retired), 32'(issued));
    end_test();

    begin_test("full pipeline under stall");
    WB_ready = 1'b0;
    for (int i = 0; i < 3; i++) begin
      send(op_by_index(i + 4), 12'(rand_bits(12)), 1'b1, 1'b0, 2'(rand_bits(2)), 1'b0);
    end
    issue_valid = 1'b0;
    repeat (7) @(posedge CLK);
    @(negedge CLK);
    check_value("issue_ready", 32'(issue_ready), 32'd0);
    check_value("WB_valid", 32'(WB_valid), 32'd1);
    @(posedge CLK);
    #1;
    WB_ready = 1'b1;
    end_test();

    begin_test("sign extension and shift edges");
    check_value("reference SRA by 31", ref_result(ALU_SRA, 32'h8000_1234, 12'd31),
                32'hffff_ffff);
    check_value("reference SRL by 31", ref_result(ALU_SRL, 32'h8000_1234, 12'd31), 32'h1);
    check_value("reference imm 0x800", ref_result(ALU_ADD, 32'h0, 12'h800), 32'hffff_f800);
    forward_data_by_bank[0] = 32'h8000_1234;
    forward_data_by_bank[1] = 32'h0000_0010;
    send(ALU_SRL, 12'd0, 1'b1, 1'b0, 2'd0, 1'b0);
    send(ALU_SRA, 12'd0, 1'b1, 1'b0, 2'd0, 1'b0);
    send(ALU_SRL, 12'd31, 1'b1, 1'b0, 2'd0, 1'b0);
    send(ALU_SRA, 12'd31, 1'b1, 1'b0, 2'd0, 1'b0);
    send(ALU_ADD, 12'h800, 1'b1, 1'b0, 2'd1, 1'b0);
    send(ALU_SLTU, 12'hfff, 1'b1, 1'b0, 2'd1, 1'b0);
    send(ALU_SLT, 12'hfff, 1'b1, 1'b0, 2'd1, 1'b0);
    send(ALU_XOR, 12'h800, 1'b1, 1'b0, 2'd1, 1'b0);
    end_test();

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
common/core_types_pkg.sv
common/alu_ops_pkg.sv
design/alu.sv
alu_imm_pipeline/alu_imm_issue_stage.sv
alu_imm_pipeline/alu_imm_operand_stage.sv
alu_imm_pipeline/alu_imm_exec_stage.sv
alu_imm_pipeline/alu_imm_pipeline.sv
tests/tb_clock_gen.sv
tests/alu_imm_pipeline_properties.sv
tests/alu_imm_pipeline_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -euo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module alu_imm_pipeline_tb \
  -f filelist.f \
  --Mdir obj_dir \
  -o alu_imm_sim

./obj_dir/alu_imm_sim 2>&1 | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
